// File: rtl/rmii_pkg.sv
package rmii_pkg;

	//////////////////////////////////////////////////////////////
	// Frame data types

	// One frame word, most significant byte goes out first
	typedef logic [31:0] eth_word_t;

	// One frame byte
	typedef logic [7:0] eth_byte_t;

	// Valid bytes in a word, 1 to 4
	typedef logic [2:0] byte_count_t;

	//////////////////////////////////////////////////////////////
	// FSM encodings

	// Transmitter sequence from preamble to FCS
	typedef enum logic [2:0] {
		TX_IDLE,
		TX_PRE1,
		TX_PRE2,
		TX_DATA,
		TX_LAST_FULL,
		TX_LAST_PART,
		TX_FCS
	} tx_state_t;

	// Word gate handshake and slot sequence
	typedef enum logic [1:0] {
		G_IDLE,
		G_WAIT_ACK_DROP,
		G_SLOT_WAIT,
		G_FRAME_DONE
	} gate_state_t;

	//////////////////////////////////////////////////////////////
	// Constants

	// 32 bits at 2 bits per clock
	localparam int unsigned SLOT_CYCLES = 16;

	localparam eth_byte_t PREAMBLE_BYTE = 8'h55;
	localparam eth_byte_t SFD_BYTE = 8'hD5;

	// Reflected IEEE 802.3 polynomial
	localparam eth_word_t CRC_POLY = 32'hEDB8_8320;
	localparam eth_word_t CRC_INIT = 32'hFFFF_FFFF;

endpackage

// File: rtl/eth_tx_if.sv
`timescale 1ns/1ps

interface eth_tx_if;
	import rmii_pkg::*;

	// Frame start pulse, also clears the CRC
	logic start;

	// One word per slot
	logic data_valid;
	byte_count_t bytes_valid;
	eth_word_t data;

	// Transmitter can take a new frame
	logic ready;

	// Word gate side
	modport gate (
		output start,
		output data_valid,
		output bytes_valid,
		output data,
		input  ready
	);

	// Transmitter side
	modport mac (
		input  start,
		input  data_valid,
		input  bytes_valid,
		input  data,
		output ready
	);

endinterface

// File: rtl/crc32_eth_x32.sv
`timescale 1ns/1ps

module crc32_eth_x32 (
	input  logic                  clk_50mhz,
	input  logic                  arst_n,
	input  logic                  clear,
	input  logic                  valid,
	input  rmii_pkg::byte_count_t len,
	input  rmii_pkg::eth_word_t   din,
	output rmii_pkg::eth_word_t   crc_out
);
	import rmii_pkg::*;

	// Running CRC register, reflected form
	eth_word_t crc_q;

	// Complemented register before the byte swap
	eth_word_t crc_inv;

	//////////////////////////////////////////////////////////////
	// Bit-serial fold of up to four bytes in one clock

	function automatic eth_word_t crc_fold(
		input eth_word_t   crc_in,
		input byte_count_t n_bytes,
		input eth_word_t   data
	);
		eth_word_t c;
		eth_byte_t b;
		int i;
		int j;
		c = crc_in;
		// Leading bytes first, top of the word down
		for (i = 0; i < 4; i++) begin
			if (i < int'(n_bytes)) begin
				b = data[(3 - i) * 8 +: 8];
				// LSB of each byte goes in first
				for (j = 0; j < 8; j++) begin
					if (c[0] ^ b[j])
						c = (c >> 1) ^ CRC_POLY;
					else
						c = c >> 1;
				end
			end
		end
		return c;
	endfunction

	//////////////////////////////////////////////////////////////
	// CRC register

	always_ff @(posedge clk_50mhz or negedge arst_n) begin
		if (!arst_n) begin
			crc_q <= CRC_INIT;
		end else if (clear) begin
			// New frame
			crc_q <= CRC_INIT;
		end else if (valid) begin
			crc_q <= crc_fold(crc_q, len, din);
		end
	end

	//////////////////////////////////////////////////////////////
	// FCS output

	assign crc_inv = ~crc_q;

	// Low byte of the FCS must be sent first
	// The transmitter sends the top byte first, hence the swap
	assign crc_out = {crc_inv[7:0], crc_inv[15:8], crc_inv[23:16], crc_inv[31:24]};

endmodule

// File: rtl/rmii_word_gate.sv
`timescale 1ns/1ps

module rmii_word_gate (
	input  logic                  clk_50mhz,
	input  logic                  arst_n,
	input  logic                  word_req,
	output logic                  word_ack,
	input  rmii_pkg::eth_word_t   word_data,
	input  rmii_pkg::byte_count_t word_bytes,
	input  logic                  word_first,
	input  logic                  word_last,
	eth_tx_if.gate                bus
);
	import rmii_pkg::*;

	gate_state_t state;

	// Cycles since the last issued word, saturates at slot end
	logic [3:0] slot_cnt;
	logic slot_open;

	// Single word holding register
	logic hold_full;
	eth_word_t hold_data;
	byte_count_t hold_bytes;
	logic hold_last;

	// Host word gets latched on this clock
	logic take_word;

	assign slot_open = (slot_cnt == 4'(SLOT_CYCLES - 1));

	always_comb begin
		case (state)
			// First word only when the transmitter is free
			G_IDLE: take_word = word_req && word_first && bus.ready;
			G_SLOT_WAIT: take_word = word_req && !hold_full;
			default: take_word = 1'b0;
		endcase
	end

	// Held word sits on the bus, valid marks the slot
	assign bus.data = hold_data;
	assign bus.bytes_valid = hold_bytes;

	always_ff @(posedge clk_50mhz) begin
		if (take_word) begin
			hold_data <= word_data;
			hold_bytes <= word_bytes;
			hold_last <= word_last;
		end
	end

	//////////////////////////////////////////////////////////////
	// Handshake and slot sequencing

	always_ff @(posedge clk_50mhz or negedge arst_n) begin
		if (!arst_n) begin
			state <= G_IDLE;
			slot_cnt <= '0;
			hold_full <= 1'b0;
			word_ack <= 1'b0;
			bus.start <= 1'b0;
			bus.data_valid <= 1'b0;
		end else begin
			bus.start <= 1'b0;
			bus.data_valid <= 1'b0;

			// Issue the held word at a slot boundary, or as soon as it shows up
			if (state != G_IDLE) begin
				if (slot_open && hold_full) begin
					bus.data_valid <= 1'b1;
					hold_full <= 1'b0;
					slot_cnt <= '0;
				end else if (!slot_open) begin
					slot_cnt <= slot_cnt + 4'd1;
				end
			end

			case (state)
				G_IDLE: begin
					if (take_word) begin
						word_ack <= 1'b1;
						bus.start <= 1'b1;
						hold_full <= 1'b1;
						// First valid lands two clocks after start
						slot_cnt <= 4'(SLOT_CYCLES - 2);
						state <= G_WAIT_ACK_DROP;
					end
				end
				G_WAIT_ACK_DROP: begin
					if (!word_req) begin
						word_ack <= 1'b0;
						state <= hold_last ? G_FRAME_DONE : G_SLOT_WAIT;
					end
				end
				G_SLOT_WAIT: begin
					if (take_word) begin
						word_ack <= 1'b1;
						hold_full <= 1'b1;
						state <= G_WAIT_ACK_DROP;
					end
				end
				// Last word still to go out
				G_FRAME_DONE: begin
					if (!hold_full)
						state <= G_IDLE;
				end
				default: state <= G_IDLE;
			endcase
		end
	end

endmodule

// File: rtl/rmii_tx_mac.sv
`timescale 1ns/1ps

module rmii_tx_mac (
	input  logic       clk_50mhz,
	input  logic       arst_n,
	eth_tx_if.mac      bus,
	output logic       rmii_rx_en,
	output logic [1:0] rmii_rxd
);
	import rmii_pkg::*;

	tx_state_t tx_state;

	// Pair index within the current word or preamble word
	logic [3:0] tx_count;

	// Word pipeline, ff1 newest and ff3 on the wire
	eth_word_t word_ff1;
	eth_word_t word_ff2;
	eth_word_t word_ff3;
	byte_count_t bytes_ff1;
	byte_count_t bytes_ff2;
	byte_count_t bytes_ff3;

	eth_word_t tx_crc;

	// Word currently being serialized
	eth_word_t cur_word;
	byte_count_t cur_bytes;

	logic self_advance;
	logic part_done;

	//////////////////////////////////////////////////////////////
	// Pair selection

	// Pairs of a byte go out low to high
	function automatic logic [1:0] byte_pair(input eth_byte_t b, input logic [1:0] k);
		return b[k * 2 +: 2];
	endfunction

	// Bytes of a word go out top down
	function automatic logic [1:0] word_pair(input eth_word_t w, input logic [3:0] idx);
		eth_byte_t b;
		b = w[(3 - idx[3:2]) * 8 +: 8];
		return byte_pair(b, idx[1:0]);
	endfunction

	//////////////////////////////////////////////////////////////
	// FCS generator

	crc32_eth_x32 u_crc (
		.clk_50mhz (clk_50mhz),
		.arst_n    (arst_n),
		.clear     (bus.start),
		.valid     (bus.data_valid),
		.len       (bus.bytes_valid),
		.din       (bus.data),
		.crc_out   (tx_crc)
	);

	//////////////////////////////////////////////////////////////
	// Word pipeline

	// New words arrive on pair 0 of each data word
	// The shift lands at the end of pair 0, so pair 0 still reads ff2
	assign cur_word = (tx_count == 4'd0) ? word_ff2 : word_ff3;
	assign cur_bytes = (tx_count == 4'd0) ? bytes_ff2 : bytes_ff3;

	// No input word on the boundary means the frame is ending
	assign self_advance = (tx_count == 4'd0) &&
		((tx_state == TX_DATA && !bus.data_valid) || tx_state == TX_LAST_PART);

	always_ff @(posedge clk_50mhz) begin
		if (bus.data_valid) begin
			word_ff1 <= bus.data;
			bytes_ff1 <= bus.bytes_valid;
			word_ff2 <= word_ff1;
			bytes_ff2 <= bytes_ff1;
			word_ff3 <= word_ff2;
			bytes_ff3 <= bytes_ff2;
		end else if (self_advance) begin
			word_ff2 <= word_ff1;
			bytes_ff2 <= bytes_ff1;
			word_ff3 <= word_ff2;
			bytes_ff3 <= bytes_ff2;
		end
	end

	// Final pair of the final valid byte
	assign part_done = (tx_count[1:0] == 2'b11) &&
		(({1'b0, tx_count[3:2]} + 3'd1) == cur_bytes);

	//////////////////////////////////////////////////////////////
	// Transmit FSM

	always_ff @(posedge clk_50mhz or negedge arst_n) begin
		if (!arst_n) begin
			tx_state <= TX_IDLE;
			tx_count <= '0;
			rmii_rx_en <= 1'b0;
			rmii_rxd <= 2'b00;
			bus.ready <= 1'b1;
		end else begin
			// Busy from start until the FCS goes out
			if (bus.start)
				bus.ready <= 1'b0;

			case (tx_state)
				TX_IDLE: begin
					rmii_rx_en <= 1'b0;
					rmii_rxd <= 2'b00;
					// First preamble pair straight away
					if (bus.data_valid) begin
						rmii_rx_en <= 1'b1;
						rmii_rxd <= byte_pair(PREAMBLE_BYTE, 2'd0);
						tx_count <= 4'd1;
						tx_state <= TX_PRE1;
					end
				end
				// Four bytes of 0x55
				TX_PRE1: begin
					rmii_rxd <= byte_pair(PREAMBLE_BYTE, tx_count[1:0]);
					tx_count <= tx_count + 4'd1;
					if (tx_count == 4'd15)
						tx_state <= TX_PRE2;
				end
				// Three more bytes of 0x55, then the SFD
				TX_PRE2: begin
					rmii_rxd <= byte_pair((tx_count[3:2] == 2'b11) ? SFD_BYTE : PREAMBLE_BYTE,
						tx_count[1:0]);
					tx_count <= tx_count + 4'd1;
					if (tx_count == 4'd15)
						tx_state <= TX_DATA;
				end
				TX_DATA: begin
					rmii_rxd <= word_pair(cur_word, tx_count);
					tx_count <= tx_count + 4'd1;
					// Only two words left in the pipeline
					if (tx_count == 4'd0 && !bus.data_valid)
						tx_state <= TX_LAST_FULL;
				end
				TX_LAST_FULL: begin
					rmii_rxd <= word_pair(cur_word, tx_count);
					tx_count <= tx_count + 4'd1;
					if (tx_count == 4'd15)
						tx_state <= TX_LAST_PART;
				end
				// 1 to 4 bytes
				TX_LAST_PART: begin
					rmii_rxd <= word_pair(cur_word, tx_count);
					tx_count <= tx_count + 4'd1;
					if (part_done) begin
						tx_count <= '0;
						tx_state <= TX_FCS;
					end
				end
				TX_FCS: begin
					rmii_rxd <= word_pair(tx_crc, tx_count);
					tx_count <= tx_count + 4'd1;
					if (tx_count == 4'd15) begin
						bus.ready <= 1'b1;
						tx_state <= TX_IDLE;
					end
				end
				default: tx_state <= TX_IDLE;
			endcase
		end
	end

endmodule

// File: rtl/rmii_mcu_bridge.sv
`timescale 1ns/1ps

module rmii_mcu_bridge (
	input  logic                  clk_50mhz,
	input  logic                  arst_n,
	input  logic                  word_req,
	output logic                  word_ack,
	input  rmii_pkg::eth_word_t   word_data,
	input  rmii_pkg::byte_count_t word_bytes,
	input  logic                  word_first,
	input  logic                  word_last,
	output logic                  rmii_rx_en,
	output logic [1:0]            rmii_rxd
);

	// Gated word bus, one word per slot
	eth_tx_if tx_bus ();

	// Host handshake to slotted words
	rmii_word_gate u_gate (
		.clk_50mhz  (clk_50mhz),
		.arst_n     (arst_n),
		.word_req   (word_req),
		.word_ack   (word_ack),
		.word_data  (word_data),
		.word_bytes (word_bytes),
		.word_first (word_first),
		.word_last  (word_last),
		.bus        (tx_bus.gate)
	);

	// Preamble, payload and FCS onto the MCU receive pins
	rmii_tx_mac u_mac (
		.clk_50mhz  (clk_50mhz),
		.arst_n     (arst_n),
		.bus        (tx_bus.mac),
		.rmii_rx_en (rmii_rx_en),
		.rmii_rxd   (rmii_rxd)
	);

endmodule

// File: testbench/tb_rmii_mcu_bridge.sv
`timescale 1ns/1ps

module tb_rmii_mcu_bridge;
	import rmii_pkg::*;

	// Wait limits in clock cycles
	localparam int ACK_WAIT = 64;
	localparam int FIRST_ACK_WAIT = 2000;
	localparam int DRAIN_WAIT = 4000;

	logic clk_50mhz;
	logic arst_n;
	logic word_req;
	logic word_ack;
	eth_word_t word_data;
	byte_count_t word_bytes;
	logic word_first;
	logic word_last;
	logic rmii_rx_en;
	logic [1:0] rmii_rxd;

	logic [31:0] rng_state = 32'h946f_5d6b;

	// Payload of the frame being driven and of the frame being compared
	eth_byte_t frame_payload [0:127];
	eth_byte_t cmp_payload [0:127];

	// Expected payloads in send order and received bytes in wire order
	eth_byte_t exp_payload [$];
	int exp_lens [$];
	eth_byte_t rx_bytes [$];
	int rx_lens [$];

	int frames_sent = 0;
	int frames_checked = 0;
	int bp_hits = 0;

	rmii_mcu_bridge u_dut (
		.clk_50mhz  (clk_50mhz),
		.arst_n     (arst_n),
		.word_req   (word_req),
		.word_ack   (word_ack),
		.word_data  (word_data),
		.word_bytes (word_bytes),
		.word_first (word_first),
		.word_last  (word_last),
		.rmii_rx_en (rmii_rx_en),
		.rmii_rxd   (rmii_rxd)
	);

	// 50 MHz
	initial begin
		clk_50mhz = 1'b0;
		forever #10 clk_50mhz = ~clk_50mhz;
	end

	////////////////////////////////////////////////////////////
	// Reference model

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Ethernet CRC-32 of the payload with the generator polynomial in normal form
	function automatic eth_word_t expected_fcs(input int n);
		logic [31:0] r;
		eth_word_t fcs;
		eth_byte_t b;
		int i;
		int j;
		r = 32'hFFFF_FFFF;
		for (i = 0; i < n; i++) begin
			b = cmp_payload[i];
			// LSB of each byte is the first bit on the wire
			for (j = 0; j < 8; j++) begin
				if (r[31] ^ b[j])
					r = (r << 1) ^ 32'h04C1_1DB7;
				else
					r = r << 1;
			end
		end
		// Complemented remainder goes out from the x^31 term down
		r = ~r;
		for (j = 0; j < 32; j++)
			fcs[j] = r[31 - j];
		return fcs;
	endfunction

	// Expected byte idx of the wire stream from preamble through FCS
	function automatic eth_byte_t expected_byte(input int idx, input int n, input eth_word_t fcs);
		int k;
		k = idx - 8 - n;
		if (idx < 7)
			return 8'h55;
		if (idx == 7)
			return 8'hD5;
		if (idx < 8 + n)
			return cmp_payload[idx - 8];
		return fcs[k * 8 +: 8];
	endfunction

	////////////////////////////////////////////////////////////
	// Checks

	task automatic stop_on_error();
		$display("TEST FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_byte(input int idx, input eth_byte_t got, input eth_byte_t exp);
		if (got !== exp) begin
			$display("[FAIL] rmii_rxd byte %0d: got 0x%h expected 0x%h", idx, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_length(input int got, input int exp);
		if (got != exp) begin
			$display("[FAIL] rmii_rx_en frame length: got 0x%h bytes expected 0x%h", got, exp);
			stop_on_error();
		end
	endtask

	// Pins at rest and optionally word_ack
	task automatic check_idle(input logic en, input logic [1:0] d, input logic ack,
		input bit with_ack);
		if (en !== 1'b0) begin
			$display("[FAIL] rmii_rx_en: got 0x%h expected 0x0", en);
			stop_on_error();
		end
		if (d !== 2'b00) begin
			$display("[FAIL] rmii_rxd: got 0x%h expected 0x0", d);
			stop_on_error();
		end
		if (with_ack && ack !== 1'b0) begin
			$display("[FAIL] word_ack: got 0x%h expected 0x0", ack);
			stop_on_error();
		end
	endtask

	////////////////////////////////////////////////////////////
	// Host driver

	// DUT outputs are sampled on the falling edge
	task automatic wait_for_ack(input logic level, input int limit, input logic wire_busy);
		int n;
		n = 0;
		@(negedge clk_50mhz);
		while (word_ack !== level) begin
			if (n >= limit) begin
				$display("Timeout: word_ack did not go to %0d within %0d cycles", level, limit);
				stop_on_error();
			end
			n++;
			@(negedge clk_50mhz);
		end
		// First word offered during a frame must wait for its end
		if (level && wire_busy) begin
			bp_hits++;
			if (rmii_rx_en !== 1'b0) begin
				$display("[FAIL] rmii_rx_en at word_ack: got 0x%h expected 0x0", rmii_rx_en);
				stop_on_error();
			end
		end
	endtask

	task automatic send_frame(input int n);
		int nwords;
		int w;
		int i;
		eth_word_t data;
		byte_count_t cnt;
		logic busy;
		for (i = 0; i < n; i++) begin
			rng_state = xorshift(rng_state);
			frame_payload[i] = rng_state[7:0];
			exp_payload.push_back(rng_state[7:0]);
		end
		exp_lens.push_back(n);
		nwords = (n + 3) / 4;
		for (w = 0; w < nwords; w++) begin
			data = '0;
			cnt = (w == nwords - 1) ? byte_count_t'(n - 4 * w) : 3'd4;
			// Most significant byte first
			for (i = 0; i < int'(cnt); i++)
				data[31 - 8 * i -: 8] = frame_payload[4 * w + i];
			@(negedge clk_50mhz);
			busy = (w == 0) && (rmii_rx_en === 1'b1);
			@(posedge clk_50mhz);
			word_data <= data;
			word_bytes <= cnt;
			word_first <= (w == 0);
			word_last <= (w == nwords - 1);
			word_req <= 1'b1;
			wait_for_ack(1'b1, (w == 0) ? FIRST_ACK_WAIT : ACK_WAIT, busy);
			@(posedge clk_50mhz);
			word_req <= 1'b0;
			wait_for_ack(1'b0, ACK_WAIT, 1'b0);
		end
		frames_sent++;
	endtask

	task automatic drain_frames();
		int n;
		n = 0;
		while (frames_checked != frames_sent) begin
			if (n >= DRAIN_WAIT) begin
				$display("Timeout: only %0d of %0d frames came out on RMII",
					frames_checked, frames_sent);
				stop_on_error();
			end
			n++;
			@(posedge clk_50mhz);
		end
	endtask

	////////////////////////////////////////////////////////////
	// RMII decoder and compare

	// Rebuilds bytes from bit pairs with the low pair first
	initial begin : decoder
		eth_byte_t cur;
		int pairs;
		logic active;
		cur = '0;
		pairs = 0;
		active = 1'b0;
		forever begin
			@(negedge clk_50mhz);
			if (rmii_rx_en === 1'b1) begin
				cur[(pairs % 4) * 2 +: 2] = rmii_rxd;
				pairs++;
				if (pairs % 4 == 0)
					rx_bytes.push_back(cur);
				active = 1'b1;
			end else if (active) begin
				if (pairs % 4 != 0) begin
					$display("Frame on RMII ended in the middle of a byte");
					stop_on_error();
				end
				check_idle(rmii_rx_en, rmii_rxd, word_ack, 1'b0);
				rx_lens.push_back(pairs / 4);
				pairs = 0;
				active = 1'b0;
			end
		end
	end

	initial begin : comparer
		int len;
		int n;
		int i;
		eth_word_t fcs;
		forever begin
			@(posedge clk_50mhz);
			if (rx_lens.size() != 0) begin
				len = rx_lens.pop_front();
				if (exp_lens.size() == 0) begin
					$display("A frame came out on RMII that the host never sent");
					stop_on_error();
				end
				n = exp_lens.pop_front();
				for (i = 0; i < n; i++)
					cmp_payload[i] = exp_payload.pop_front();
				// Eight bytes of preamble and SFD plus four of FCS
				check_length(len, n + 12);
				fcs = expected_fcs(n);
				for (i = 0; i < len; i++)
					check_byte(i, rx_bytes.pop_front(), expected_byte(i, n, fcs));
				frames_checked++;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Test sequence

	initial begin : main_seq
		int k;
		int n;
		word_req <= 1'b0;
		word_data <= '0;
		word_bytes <= 3'd4;
		word_first <= 1'b0;
		word_last <= 1'b0;
		arst_n <= 1'b0;
		repeat (16) @(posedge clk_50mhz);
		arst_n <= 1'b1;

		// Quiet pins after reset
		repeat (4) begin
			@(negedge clk_50mhz);
			check_idle(rmii_rx_en, rmii_rxd, word_ack, 1'b1);
		end

		// Last word of 4, 1, 2 and 3 bytes
		for (k = 0; k < 4; k++) begin
			rng_state = xorshift(rng_state);
			n = 60 + 4 * int'(rng_state % 32'd17) + k;
			send_frame(n);
		end

		// Back to back frames of random length 60 to 127
		for (k = 0; k < 20; k++) begin
			rng_state = xorshift(rng_state);
			n = 60 + int'(rng_state % 32'd68);
			send_frame(n);
		end

		drain_frames();
		repeat (8) begin
			@(negedge clk_50mhz);
			check_idle(rmii_rx_en, rmii_rxd, word_ack, 1'b1);
		end

		if (bp_hits == 0) begin
			$display("No first word was ever offered while a frame was on the wire");
			stop_on_error();
		end else begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule

// File: sim.f
rtl/rmii_pkg.sv
rtl/eth_tx_if.sv
rtl/crc32_eth_x32.sv
rtl/rmii_word_gate.sv
rtl/rmii_tx_mac.sv
rtl/rmii_mcu_bridge.sv
testbench/tb_rmii_mcu_bridge.sv

// File: run_sim.sh
#!/bin/sh
# Builds the RMII bridge testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_rmii_mcu_bridge
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/Vtb_rmii_mcu_bridge 2>&1)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
	exit 0
fi
echo "Pass line not found in simulation output"
exit 1
